// ==== verilog/eth_parser_consts.svh ====
/*
  Ethernet parser constants
  Stream geometry, header capture size and EtherType codes
*/
`ifndef ETH_PARSER_CONSTS_SVH
`define ETH_PARSER_CONSTS_SVH

// Stream geometry
`define ETH_DATA_WIDTH 64
`define ETH_BEAT_BYTES 8

// Header capture window
`define ETH_HDR_BYTES 18
`define ETH_HDR_BEATS 3

// TPID and EtherType codes, network order
`define ETH_TPID_VLAN 16'h8100
`define ETH_TYPE_IPV4 16'h0800
`define ETH_TYPE_IPV6 16'h86DD
`define ETH_TYPE_ARP  16'h0806

// L2 header lengths in bytes
`define ETH_L2_LEN_UNTAGGED 5'd14
`define ETH_L2_LEN_TAGGED   5'd18

`endif

// ==== verilog/eth_parser_pkg.sv ====
/*
  Ethernet parser types
  Vector typedefs for meaningful widths and the frame state enum
*/
`include "eth_parser_consts.svh"

package eth_parser_pkg;

  // ============================
  // Data path
  // ============================
  // One stream beat, byte 0 in bits 7:0
  typedef logic [`ETH_DATA_WIDTH-1:0] beat_t;

  // ============================
  // Header fields
  // ============================
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] ethertype_t;
  typedef logic [11:0] vlan_id_t;

  // L2 header length, 14 or 18
  typedef logic [4:0] hdr_len_t;

  // Beats seen in the frame, saturates at 3
  typedef logic [1:0] hdr_beats_t;

  // Captured header, byte i at bits 8*i+7:8*i
  typedef logic [`ETH_HDR_BYTES*8-1:0] hdr_bytes_t;

  // Frame tracking states
  typedef enum logic [1:0] {
    IDLE,
    HEADER,
    PAYLOAD
  } frame_state_t;

endpackage

// ==== verilog/axis_reg_slice.sv ====
/*
  Stream register slice
  Two-entry skid buffer, full throughput, registered ready
*/
module axis_reg_slice #(
  parameter int WIDTH = 64
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_last,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [WIDTH-1:0] out_data,
  output logic             out_last,
  output logic             out_valid,
  input  logic             out_ready
);

  // Skid entry, holds one beat caught while output stalls
  logic [WIDTH-1:0] skid_data;
  logic             skid_last;
  logic             skid_valid;

  logic in_fire;
  logic out_free;

  assign in_fire  = in_valid & in_ready;
  // Output register can take a new beat
  assign out_free = ~out_valid | out_ready;

  // ============================
  // Control
  // ============================
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else begin
      if (out_free) begin
        // Skid drains first, else pass the incoming beat
        out_valid  <= skid_valid | in_fire;
        skid_valid <= 1'b0;
        in_ready   <= 1'b1;
      end else if (in_fire) begin
        // Output stalled, park the beat and close ready
        skid_valid <= 1'b1;
        in_ready   <= 1'b0;
      end
    end
  end

  // ============================
  // Data
  // ============================
  always_ff @(posedge clk) begin
    if (out_free) begin
      if (skid_valid) begin
        out_data <= skid_data;
        out_last <= skid_last;
      end else if (in_fire) begin
        out_data <= in_data;
        out_last <= in_last;
      end
    end else if (in_fire) begin
      skid_data <= in_data;
      skid_last <= in_last;
    end
  end

endmodule

// ==== verilog/frame_control_fsm.sv ====
/*
  Frame control FSM
  Tracks frame boundaries and header beat count from accepted beats
*/
`include "eth_parser_consts.svh"

module frame_control_fsm
  import eth_parser_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       beat_accept,
  input  logic       tlast,
  output logic       frame_start,
  output logic       frame_end,
  output hdr_beats_t header_beats
);

  frame_state_t state;
  frame_state_t state_next;

  // IDLE is also the state right after a tlast beat
  assign frame_start = beat_accept & (state == IDLE);

  // ============================
  // Next state
  // ============================
  always_comb begin
    state_next = state;
    if (beat_accept) begin
      case (state)
        IDLE: begin
          // One-beat frame goes straight back
          state_next = tlast ? IDLE : HEADER;
        end
        HEADER: begin
          if (tlast) begin
            state_next = IDLE;
          end else if (header_beats == hdr_beats_t'(`ETH_HDR_BEATS - 1)) begin
            // Third header beat taken
            state_next = PAYLOAD;
          end
        end
        PAYLOAD: begin
          if (tlast) begin
            state_next = IDLE;
          end
        end
        default: state_next = IDLE;
      endcase
    end
  end

  // ============================
  // State, end pulse, beat count
  // ============================
  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= IDLE;
      frame_end    <= 1'b0;
      header_beats <= '0;
    end else begin
      state     <= state_next;
      // One cycle after the tlast accept
      frame_end <= beat_accept & tlast;
      if (frame_start) begin
        header_beats <= hdr_beats_t'(1);
      end else if (beat_accept && header_beats != hdr_beats_t'(`ETH_HDR_BEATS)) begin
        header_beats <= header_beats + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/header_shift_register.sv ====
/*
  Header capture
  Writes the first three beats of a frame into an 18-byte array
*/
`include "eth_parser_consts.svh"

module header_shift_register
  import eth_parser_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       beat_accept,
  input  logic       frame_start,
  input  hdr_beats_t header_beats,
  input  beat_t      axis_tdata,
  output hdr_bytes_t header_bytes
);

  // Beat slot for this accept, first beat always slot 0
  hdr_beats_t slot;

  assign slot = frame_start ? '0 : header_beats;

  always_ff @(posedge clk) begin
    if (rst) begin
      header_bytes <= '0;
    end else if (beat_accept) begin
      // Fresh frame, stale bytes cleared so short frames read zero
      if (frame_start) begin
        header_bytes <= '0;
      end
      // Beats past the third are not kept
      if (slot != hdr_beats_t'(`ETH_HDR_BEATS)) begin
        for (int i = 0; i < `ETH_HDR_BYTES; i++) begin
          // Bytes 18..23 of slot 2 fall off the end
          if (i / `ETH_BEAT_BYTES == int'(slot)) begin
            header_bytes[8*i +: 8] <= axis_tdata[8*(i % `ETH_BEAT_BYTES) +: 8];
          end
        end
      end
    end
  end

endmodule

// ==== verilog/header_decoder.sv ====
/*
  Header decoder
  MACs, single VLAN tag, EtherType, length, class and runt flags
*/
`include "eth_parser_consts.svh"

module header_decoder
  import eth_parser_pkg::*;
(
  input  hdr_bytes_t header_bytes,
  input  hdr_beats_t header_beats,
  output mac_addr_t  dest_mac,
  output mac_addr_t  src_mac,
  output ethertype_t ethertype,
  output logic       vlan_present,
  output vlan_id_t   vlan_id,
  output hdr_len_t   l2_len,
  output logic       is_ipv4,
  output logic       is_ipv6,
  output logic       is_arp,
  output logic       is_unknown,
  output logic       is_runt
);

  // Header as a byte array, wire order
  logic [7:0] hb [`ETH_HDR_BYTES];

  ethertype_t outer_type;
  ethertype_t tag_tci;

  always_comb begin
    for (int i = 0; i < `ETH_HDR_BYTES; i++) begin
      hb[i] = header_bytes[8*i +: 8];
    end
  end

  // ============================
  // Addresses
  // ============================
  // First byte on the wire is the MSB
  assign dest_mac = {hb[0], hb[1], hb[2], hb[3], hb[4], hb[5]};
  assign src_mac  = {hb[6], hb[7], hb[8], hb[9], hb[10], hb[11]};

  // ============================
  // Tag resolution
  // ============================
  assign outer_type   = {hb[12], hb[13]};
  assign tag_tci      = {hb[14], hb[15]};
  assign vlan_present = (outer_type == `ETH_TPID_VLAN);

  // PCP and DEI bits dropped
  assign vlan_id   = vlan_present ? tag_tci[11:0] : '0;
  assign ethertype = vlan_present ? {hb[16], hb[17]} : outer_type;
  assign l2_len    = vlan_present ? `ETH_L2_LEN_TAGGED : `ETH_L2_LEN_UNTAGGED;

  // ============================
  // Runt and class
  // ============================
  // Too short for the EtherType it needs
  assign is_runt = (header_beats < hdr_beats_t'(2)) ||
                   (vlan_present && header_beats == hdr_beats_t'(2));

  assign is_ipv4 = ~is_runt & (ethertype == `ETH_TYPE_IPV4);
  assign is_ipv6 = ~is_runt & (ethertype == `ETH_TYPE_IPV6);
  assign is_arp  = ~is_runt & (ethertype == `ETH_TYPE_ARP);

  // Catch-all, also taken by runts
  assign is_unknown = ~(is_ipv4 | is_ipv6 | is_arp);

endmodule

// ==== verilog/metadata_packager.sv ====
/*
  Metadata packager
  Latches decoded fields at frame end, emits a one-cycle valid
*/
module metadata_packager
  import eth_parser_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       frame_end,
  input  mac_addr_t  dest_mac,
  input  mac_addr_t  src_mac,
  input  ethertype_t ethertype,
  input  logic       vlan_present,
  input  vlan_id_t   vlan_id,
  input  hdr_len_t   l2_len,
  input  logic       is_ipv4,
  input  logic       is_ipv6,
  input  logic       is_arp,
  input  logic       is_unknown,
  input  logic       is_runt,
  output logic       meta_valid,
  output mac_addr_t  meta_dest_mac,
  output mac_addr_t  meta_src_mac,
  output ethertype_t meta_ethertype,
  output logic       meta_vlan_present,
  output vlan_id_t   meta_vlan_id,
  output hdr_len_t   meta_l2_len,
  output logic       meta_is_ipv4,
  output logic       meta_is_ipv6,
  output logic       meta_is_arp,
  output logic       meta_is_unknown,
  output logic       meta_is_runt
);

  // Pulse follows frame_end by one edge
  always_ff @(posedge clk) begin
    if (rst) begin
      meta_valid <= 1'b0;
    end else begin
      meta_valid <= frame_end;
    end
  end

  // Sampled before a back-to-back frame overwrites the header
  always_ff @(posedge clk) begin
    if (frame_end) begin
      meta_dest_mac     <= dest_mac;
      meta_src_mac      <= src_mac;
      meta_ethertype    <= ethertype;
      meta_vlan_present <= vlan_present;
      meta_vlan_id      <= vlan_id;
      meta_l2_len       <= l2_len;
      meta_is_ipv4      <= is_ipv4;
      meta_is_ipv6      <= is_ipv6;
      meta_is_arp       <= is_arp;
      meta_is_unknown   <= is_unknown;
      meta_is_runt      <= is_runt;
    end
  end

endmodule

// ==== verilog/ethernet_frame_parser.sv ====
/*
  Ethernet L2 frame parser
  Passes the stream through and reports per-frame header metadata
*/
`include "eth_parser_consts.svh"

module ethernet_frame_parser
  import eth_parser_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  // Input stream
  input  beat_t      s_axis_tdata,
  input  logic       s_axis_tvalid,
  output logic       s_axis_tready,
  input  logic       s_axis_tlast,

  // Output stream
  output beat_t      m_axis_tdata,
  output logic       m_axis_tvalid,
  input  logic       m_axis_tready,
  output logic       m_axis_tlast,

  // Metadata sideband, no back-pressure
  output logic       meta_valid,
  output mac_addr_t  meta_dest_mac,
  output mac_addr_t  meta_src_mac,
  output ethertype_t meta_ethertype,
  output logic       meta_vlan_present,
  output vlan_id_t   meta_vlan_id,
  output hdr_len_t   meta_l2_len,
  output logic       meta_is_ipv4,
  output logic       meta_is_ipv6,
  output logic       meta_is_arp,
  output logic       meta_is_unknown,
  output logic       meta_is_runt
);

  // Internal stream between the slices
  beat_t axis_tdata;
  logic  axis_tvalid;
  logic  axis_tready;
  logic  axis_tlast;
  logic  beat_accept;

  logic       frame_start;
  logic       frame_end;
  hdr_beats_t header_beats;
  hdr_bytes_t header_bytes;

  mac_addr_t  dest_mac;
  mac_addr_t  src_mac;
  ethertype_t ethertype;
  logic       vlan_present;
  vlan_id_t   vlan_id;
  hdr_len_t   l2_len;
  logic       is_ipv4;
  logic       is_ipv6;
  logic       is_arp;
  logic       is_unknown;
  logic       is_runt;

  // Beat crossing from ingress into egress
  assign beat_accept = axis_tvalid & axis_tready;

  // ============================
  // Stream path
  // ============================
  axis_reg_slice #(
    .WIDTH (`ETH_DATA_WIDTH)
  ) u_ingress (
    .clk       (clk),
    .rst       (rst),
    .in_data   (s_axis_tdata),
    .in_last   (s_axis_tlast),
    .in_valid  (s_axis_tvalid),
    .in_ready  (s_axis_tready),
    .out_data  (axis_tdata),
    .out_last  (axis_tlast),
    .out_valid (axis_tvalid),
    .out_ready (axis_tready)
  );

  axis_reg_slice #(
    .WIDTH (`ETH_DATA_WIDTH)
  ) u_egress (
    .clk       (clk),
    .rst       (rst),
    .in_data   (axis_tdata),
    .in_last   (axis_tlast),
    .in_valid  (axis_tvalid),
    .in_ready  (axis_tready),
    .out_data  (m_axis_tdata),
    .out_last  (m_axis_tlast),
    .out_valid (m_axis_tvalid),
    .out_ready (m_axis_tready)
  );

  // ============================
  // Frame tracking and capture
  // ============================
  frame_control_fsm u_fsm (
    .clk          (clk),
    .rst          (rst),
    .beat_accept  (beat_accept),
    .tlast        (axis_tlast),
    .frame_start  (frame_start),
    .frame_end    (frame_end),
    .header_beats (header_beats)
  );

  header_shift_register u_hdr_capture (
    .clk          (clk),
    .rst          (rst),
    .beat_accept  (beat_accept),
    .frame_start  (frame_start),
    .header_beats (header_beats),
    .axis_tdata   (axis_tdata),
    .header_bytes (header_bytes)
  );

  // ============================
  // Decode and metadata
  // ============================
  header_decoder u_decoder (
    .header_bytes (header_bytes),
    .header_beats (header_beats),
    .dest_mac     (dest_mac),
    .src_mac      (src_mac),
    .ethertype    (ethertype),
    .vlan_present (vlan_present),
    .vlan_id      (vlan_id),
    .l2_len       (l2_len),
    .is_ipv4      (is_ipv4),
    .is_ipv6      (is_ipv6),
    .is_arp       (is_arp),
    .is_unknown   (is_unknown),
    .is_runt      (is_runt)
  );

  metadata_packager u_meta (
    .clk               (clk),
    .rst               (rst),
    .frame_end         (frame_end),
    .dest_mac          (dest_mac),
    .src_mac           (src_mac),
    .ethertype         (ethertype),
    .vlan_present      (vlan_present),
    .vlan_id           (vlan_id),
    .l2_len            (l2_len),
    .is_ipv4           (is_ipv4),
    .is_ipv6           (is_ipv6),
    .is_arp            (is_arp),
    .is_unknown        (is_unknown),
    .is_runt           (is_runt),
    .meta_valid        (meta_valid),
    .meta_dest_mac     (meta_dest_mac),
    .meta_src_mac      (meta_src_mac),
    .meta_ethertype    (meta_ethertype),
    .meta_vlan_present (meta_vlan_present),
    .meta_vlan_id      (meta_vlan_id),
    .meta_l2_len       (meta_l2_len),
    .meta_is_ipv4      (meta_is_ipv4),
    .meta_is_ipv6      (meta_is_ipv6),
    .meta_is_arp       (meta_is_arp),
    .meta_is_unknown   (meta_is_unknown),
    .meta_is_runt      (meta_is_runt)
  );

endmodule

// ==== verif/ethernet_frame_parser_assert.sv ====
/*
  Parser protocol checks
  Output stream hold rule, metadata pulse and class flags
*/
module ethernet_frame_parser_assert
  import eth_parser_pkg::*;
(
  input logic  clk,
  input logic  rst,
  input beat_t m_axis_tdata,
  input logic  m_axis_tvalid,
  input logic  m_axis_tready,
  input logic  m_axis_tlast,
  input logic  meta_valid,
  input logic  meta_is_ipv4,
  input logic  meta_is_ipv6,
  input logic  meta_is_arp,
  input logic  meta_is_unknown
);

  timeunit 1ns;
  timeprecision 1ps;

  // Failures seen so far
  int unsigned violation_count = 0;

  // ============================
  // Stream rules
  // ============================
  // Beat held while stalled
  hold_under_stall: assert property (@(posedge clk) disable iff (rst)
    (m_axis_tvalid && !m_axis_tready) |=>
      (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)))
  else begin
    violation_count++;
    $error("m_axis beat changed while stalled");
  end

  // Output idle through reset
  idle_in_reset: assert property (@(posedge clk) rst |=> !m_axis_tvalid)
  else begin
    violation_count++;
    $error("m_axis_tvalid high during reset");
  end

  // ============================
  // Metadata rules
  // ============================
  single_pulse: assert property (@(posedge clk) disable iff (rst)
    meta_valid |=> !meta_valid)
  else begin
    violation_count++;
    $error("meta_valid high for two cycles");
  end

  one_class: assert property (@(posedge clk) disable iff (rst)
    meta_valid |-> $onehot({meta_is_ipv4, meta_is_ipv6, meta_is_arp, meta_is_unknown}))
  else begin
    violation_count++;
    $error("class flags not one-hot at meta_valid");
  end

endmodule

bind ethernet_frame_parser ethernet_frame_parser_assert u_assert (.*);

// ==== verif/tb_ethernet_frame_parser.sv ====
/*
  Testbench for the Ethernet L2 frame parser
  File-driven frames, stream scoreboard and metadata checks
*/
`include "eth_parser_consts.svh"

module tb_ethernet_frame_parser
  import eth_parser_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_FRAMES   = 32;
  localparam int WAIT_LIMIT   = 200;
  localparam int DRIVE_DELAY  = 2;
  localparam int QUIET_CYCLES = 20;

  logic       clk;
  logic       rst;
  beat_t      s_axis_tdata;
  logic       s_axis_tvalid;
  logic       s_axis_tready;
  logic       s_axis_tlast;
  beat_t      m_axis_tdata;
  logic       m_axis_tvalid;
  logic       m_axis_tready;
  logic       m_axis_tlast;
  logic       meta_valid;
  mac_addr_t  meta_dest_mac;
  mac_addr_t  meta_src_mac;
  ethertype_t meta_ethertype;
  logic       meta_vlan_present;
  vlan_id_t   meta_vlan_id;
  hdr_len_t   meta_l2_len;
  logic       meta_is_ipv4;
  logic       meta_is_ipv6;
  logic       meta_is_arp;
  logic       meta_is_unknown;
  logic       meta_is_runt;

  // ============================
  // Frame table from the file
  // ============================
  int          n_frames;
  int          frm_beats    [MAX_FRAMES];
  mac_addr_t   frm_dmac     [MAX_FRAMES];
  mac_addr_t   frm_smac     [MAX_FRAMES];
  ethertype_t  frm_b12      [MAX_FRAMES];
  logic [31:0] frm_b14      [MAX_FRAMES];
  logic [15:0] frm_in_mask  [MAX_FRAMES];
  logic [15:0] frm_out_mask [MAX_FRAMES];
  ethertype_t  exp_type     [MAX_FRAMES];
  logic        exp_vlan     [MAX_FRAMES];
  vlan_id_t    exp_vid      [MAX_FRAMES];
  hdr_len_t    exp_len      [MAX_FRAMES];
  int          exp_class    [MAX_FRAMES];
  logic        exp_runt     [MAX_FRAMES];

  // Sent beats in order as {last, data}
  logic [64:0] sent_q [$];
  logic [31:0] rng_state = 32'd9;

  ethernet_frame_parser ethernet_frame_parser_inst (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ============================
  // Failure reporting
  // ============================
  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic report_mismatch(string sig, logic [63:0] exp_v, logic [63:0] act_v);
    $display("FAILED time=%0t signal=%s expected=0x%0h actual=0x%0h", $time, sig, exp_v, act_v);
    stop_with_failure();
  endtask

  task automatic report_error(string what);
    $display("ERROR at %0t: %s", $time, what);
    stop_with_failure();
  endtask

  // Result compares
  task automatic check_beat(beat_t exp_data, logic exp_last, beat_t act_data, logic act_last);
    if (act_data !== exp_data) report_mismatch("m_axis_tdata", exp_data, act_data);
    if (act_last !== exp_last) report_mismatch("m_axis_tlast", exp_last, act_last);
  endtask

  task automatic check_mac(string sig, mac_addr_t exp_v, mac_addr_t act_v);
    if (act_v !== exp_v) report_mismatch(sig, exp_v, act_v);
  endtask

  task automatic check_ethertype(string sig, ethertype_t exp_v, ethertype_t act_v);
    if (act_v !== exp_v) report_mismatch(sig, exp_v, act_v);
  endtask

  task automatic check_vlan(string sig, vlan_id_t exp_v, vlan_id_t act_v);
    if (act_v !== exp_v) report_mismatch(sig, exp_v, act_v);
  endtask

  task automatic check_len(string sig, hdr_len_t exp_v, hdr_len_t act_v);
    if (act_v !== exp_v) report_mismatch(sig, exp_v, act_v);
  endtask

  task automatic check_flag(string sig, logic exp_v, logic act_v);
    if (act_v !== exp_v) report_mismatch(sig, exp_v, act_v);
  endtask

  // xorshift32 for payload bytes
  function automatic logic [31:0] next_random(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ============================
  // Stimulus file
  // ============================
  task automatic load_stimulus();
    int          fd;
    int          cnt;
    int          beats;
    int          vlan;
    int          len;
    int          cls;
    int          runt;
    string       line;
    mac_addr_t   d;
    mac_addr_t   s;
    logic [15:0] b12;
    logic [31:0] b14;
    logic [15:0] im;
    logic [15:0] om;
    logic [15:0] et;
    logic [11:0] vid;
    fd = $fopen("verif/eth_parser_stim.txt", "r");
    if (fd == 0) report_error("cannot open verif/eth_parser_stim.txt");
    n_frames = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Skip blanks and column notes
      if (line.len() < 2 || line.getc(0) == "#") continue;
      cnt = $sscanf(line, "%d %h %h %h %h %h %h %h %d %h %d %d %d",
                    beats, d, s, b12, b14, im, om, et, vlan, vid, len, cls, runt);
      if (cnt != 13) report_error({"malformed stimulus line: ", line});
      if (n_frames == MAX_FRAMES) report_error("too many frames in stimulus file");
      if (im == 16'hFFFF || om == 16'hFFFF) report_error("stall mask never lets a beat through");
      frm_beats[n_frames]    = beats;
      frm_dmac[n_frames]     = d;
      frm_smac[n_frames]     = s;
      frm_b12[n_frames]      = b12;
      frm_b14[n_frames]      = b14;
      frm_in_mask[n_frames]  = im;
      frm_out_mask[n_frames] = om;
      exp_type[n_frames]     = et;
      exp_vlan[n_frames]     = vlan[0];
      exp_vid[n_frames]      = vid;
      exp_len[n_frames]      = hdr_len_t'(len);
      exp_class[n_frames]    = cls;
      exp_runt[n_frames]     = runt[0];
      n_frames++;
    end
    $fclose(fd);
    if (n_frames == 0) report_error("stimulus file holds no frames");
  endtask

  // Header bytes in wire order with byte i at bits 8*i+7:8*i
  function automatic hdr_bytes_t wire_header(int f);
    hdr_bytes_t h;
    for (int i = 0; i < 6; i++) begin
      h[8*i +: 8]     = frm_dmac[f][47-8*i -: 8];
      h[8*(i+6) +: 8] = frm_smac[f][47-8*i -: 8];
    end
    h[8*12 +: 8] = frm_b12[f][15:8];
    h[8*13 +: 8] = frm_b12[f][7:0];
    for (int i = 0; i < 4; i++) begin
      h[8*(14+i) +: 8] = frm_b14[f][31-8*i -: 8];
    end
    return h;
  endfunction

  // MAC as captured with unsent bytes read as zero
  function automatic mac_addr_t seen_mac(int f, int first);
    mac_addr_t full;
    mac_addr_t m;
    full = (first == 0) ? frm_dmac[f] : frm_smac[f];
    for (int i = 0; i < 6; i++) begin
      m[47-8*i -: 8] = (first + i < 8 * frm_beats[f]) ? full[47-8*i -: 8] : 8'h00;
    end
    return m;
  endfunction

  // ============================
  // Driver and monitors
  // ============================
  task automatic drive_frame(int f);
    hdr_bytes_t hdr;
    beat_t      data;
    int         cyc;
    int         waited;
    bit         done;
    hdr = wire_header(f);
    cyc = 0;
    for (int b = 0; b < frm_beats[f]; b++) begin
      for (int k = 0; k < `ETH_BEAT_BYTES; k++) begin
        if (8*b + k < `ETH_HDR_BYTES) begin
          data[8*k +: 8] = hdr[8*(8*b+k) +: 8];
        end else begin
          rng_state      = next_random(rng_state);
          data[8*k +: 8] = rng_state[7:0];
        end
      end
      // Input gaps from the mask
      while (frm_in_mask[f][cyc % 16]) begin
        s_axis_tvalid = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
        cyc++;
      end
      s_axis_tdata  = data;
      s_axis_tlast  = (b == frm_beats[f] - 1);
      s_axis_tvalid = 1'b1;
      waited = 0;
      done   = 1'b0;
      while (!done) begin
        @(negedge clk);
        if (s_axis_tready) begin
          sent_q.push_back({s_axis_tlast, s_axis_tdata});
          done = 1'b1;
        end else if (waited == WAIT_LIMIT) begin
          report_error($sformatf("timeout waiting for s_axis_tready in frame %0d", f));
        end
        waited++;
        @(posedge clk);
        #DRIVE_DELAY;
        cyc++;
      end
    end
    s_axis_tvalid = 1'b0;
  endtask

  task automatic watch_output();
    int          f;
    int          cyc;
    int          idle;
    bit          frame_done;
    logic [64:0] exp_beat;
    f   = 0;
    cyc = 0;
    idle = 0;
    while (f < n_frames) begin
      m_axis_tready = ~frm_out_mask[f][cyc % 16];
      frame_done    = 1'b0;
      @(negedge clk);
      if (m_axis_tvalid && m_axis_tready) begin
        if (sent_q.size() == 0) report_error("output beat with no matching input beat");
        exp_beat = sent_q.pop_front();
        check_beat(exp_beat[63:0], exp_beat[64], m_axis_tdata, m_axis_tlast);
        idle       = 0;
        frame_done = m_axis_tlast;
      end else begin
        idle++;
        if (idle == WAIT_LIMIT) report_error("timeout waiting for m_axis_tvalid");
      end
      @(posedge clk);
      #DRIVE_DELAY;
      if (frame_done) begin
        f++;
        cyc = 0;
      end else begin
        cyc++;
      end
    end
    m_axis_tready = 1'b1;
  endtask

  task automatic watch_metadata();
    int waited;
    for (int f = 0; f < n_frames; f++) begin
      waited = 0;
      @(negedge clk);
      while (!meta_valid) begin
        if (waited == WAIT_LIMIT) begin
          report_error($sformatf("timeout waiting for meta_valid of frame %0d", f));
        end
        waited++;
        @(negedge clk);
      end
      check_mac("meta_dest_mac", seen_mac(f, 0), meta_dest_mac);
      check_mac("meta_src_mac", seen_mac(f, 6), meta_src_mac);
      check_ethertype("meta_ethertype", exp_type[f], meta_ethertype);
      check_flag("meta_vlan_present", exp_vlan[f], meta_vlan_present);
      check_vlan("meta_vlan_id", exp_vid[f], meta_vlan_id);
      check_len("meta_l2_len", exp_len[f], meta_l2_len);
      // Class code 0 IPv4, 1 IPv6, 2 ARP, 3 unknown
      check_flag("meta_is_ipv4", exp_class[f] == 0, meta_is_ipv4);
      check_flag("meta_is_ipv6", exp_class[f] == 1, meta_is_ipv6);
      check_flag("meta_is_arp", exp_class[f] == 2, meta_is_arp);
      check_flag("meta_is_unknown", exp_class[f] == 3, meta_is_unknown);
      check_flag("meta_is_runt", exp_runt[f], meta_is_runt);
    end
  endtask

  // Assertion failures from the bound checker
  initial begin
    forever begin
      @(negedge clk);
      if (ethernet_frame_parser_inst.u_assert.violation_count != 0) begin
        report_error("a bound assertion on the DUT fired");
      end
    end
  end

  // ============================
  // Main sequence
  // ============================
  initial begin
    rst           = 1'b1;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b0;
    load_stimulus();
    repeat (8) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    fork
      begin
        for (int f = 0; f < n_frames; f++) begin
          drive_frame(f);
        end
      end
      watch_output();
      watch_metadata();
    join
    // Nothing may follow the last frame
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      if (m_axis_tvalid) report_error("stray m_axis beat after the last frame");
      if (meta_valid) report_error("stray meta_valid pulse after the last frame");
    end
    if (ethernet_frame_parser_inst.u_assert.violation_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      report_error("a bound assertion on the DUT fired");
    end
  end

endmodule

// ==== verif/eth_parser_stim.txt ====
# beats dest_mac src_mac bytes12_13 bytes14_17 in_stall out_stall exp_ethertype exp_vlan exp_vid exp_len class runt
# class 0 IPv4, 1 IPv6, 2 ARP, 3 unknown; stall masks hex, bit n stalls cycle n mod 16 of the frame
4 0A1B2C3D4E5F 001122334455 0800 45000054 0000 0000 0800 0 000 14 0 0
5 0A1B2C3D4E5F 001122334456 86DD 60000000 0000 0000 86DD 0 000 14 1 0
6 FFFFFFFFFFFF 001122334457 0806 00010800 0000 0000 0806 0 000 14 2 0
1 0A1B2C3D4E5F 665544332211 0800 45000054 0007 0000 0000 0 000 14 3 1
2 020000000001 020000000002 0800 45000028 0000 0000 0800 0 000 14 0 0
2 020000000001 020000000003 8100 00640800 0000 0000 0000 1 064 18 3 1
4 0A1B2C3D4E5F 001122334455 8100 A0640800 0000 0000 0800 1 064 18 0 0
5 3333FF000001 001122334455 8100 3FFF86DD 0000 0000 86DD 1 FFF 18 1 0
3 FFFFFFFFFFFF 0022446688AA 8100 00010806 0000 0000 0806 1 001 18 2 0
4 0180C200000E 0022446688AB 8100 012388CC 0000 0000 88CC 1 123 18 3 0
6 0180C200000E 0022446688AC 88B5 00000000 0000 0000 88B5 0 000 14 3 0
4 0A0000000001 0B0000000001 0800 45000030 0000 0000 0800 0 000 14 0 0
5 0A0000000002 0B0000000002 0806 00010800 0000 0000 0806 0 000 14 2 0
4 0A0000000003 0B0000000003 86DD 60012345 0000 0000 86DD 0 000 14 1 0
8 0A0000000004 0B0000000004 8100 E0050800 0000 0000 0800 1 005 18 0 0
5 0C0000000001 0D0000000001 0800 4500003C 5A21 3C81 0800 0 000 14 0 0
7 0C0000000002 0D0000000002 8100 21F486DD 1248 8421 86DD 1 1F4 18 1 0
4 0C0000000003 0D0000000003 0806 00010800 0F00 00F0 0806 0 000 14 2 0
6 0C0000000004 0D0000000004 8100 0FFE9000 A5A5 5A5A 9000 1 FFE 18 3 0
8 0C0000000005 0D0000000005 86DD 6AB00000 3333 C3C3 86DD 0 000 14 1 0
3 0C0000000006 0D0000000006 0800 45100040 0101 1010 0800 0 000 14 0 0

// ==== flist.f ====
+incdir+verilog
verilog/eth_parser_pkg.sv
verilog/axis_reg_slice.sv
verilog/frame_control_fsm.sv
verilog/header_shift_register.sv
verilog/header_decoder.sv
verilog/metadata_packager.sv
verilog/ethernet_frame_parser.sv
verif/ethernet_frame_parser_assert.sv
verif/tb_ethernet_frame_parser.sv

// ==== Bender.yml ====
package:
  name: ethernet_frame_parser

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/eth_parser_pkg.sv
      - verilog/axis_reg_slice.sv
      - verilog/frame_control_fsm.sv
      - verilog/header_shift_register.sv
      - verilog/header_decoder.sv
      - verilog/metadata_packager.sv
      - verilog/ethernet_frame_parser.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/ethernet_frame_parser_assert.sv
      - verif/tb_ethernet_frame_parser.sv
